//--- hw/fetch_issue_pkg.sv
package fetch_issue_pkg;

  localparam int TAG_W = 4;   // reorder buffer has 16 slots
  localparam int XLEN  = 32;

  // major opcodes the front end understands, everything else is illegal
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [2:0] {
    CLS_LUI,
    CLS_AUIPC,
    CLS_JAL,
    CLS_BRANCH,
    CLS_OP_IMM,
    CLS_OP,
    CLS_ILLEGAL
  } instr_class_e;

  // encoding shared with the ALU in the reservation station
  typedef enum logic [3:0] {
    ALU_NOP  = 4'd0,
    ALU_AND  = 4'd1,
    ALU_OR   = 4'd2,
    ALU_XOR  = 4'd3,
    ALU_ADD  = 4'd4,
    ALU_SUB  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLL  = 4'd8,
    ALU_LT   = 4'd9,
    ALU_LTU  = 4'd10,
    ALU_EQ   = 4'd11,
    ALU_NE   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_GEU  = 4'd14,
    ALU_RSVD = 4'd15
  } alu_op_e;

  typedef enum logic [1:0] {
    ROB_REG    = 2'b00,
    ROB_STORE  = 2'b01,
    ROB_BRANCH = 2'b10,
    ROB_JALR   = 2'b11
  } rob_class_e;

  typedef struct packed {
    instr_class_e    cls;
    logic [4:0]      rd;        // zero when the class writes no register
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] imm;       // already sign extended
    alu_op_e         alu_op;
    logic            uses_rs1;
    logic            uses_rs2;
  } decoded_instr_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  value;
  } cdb_t;

  typedef struct packed {
    logic [XLEN-1:0]  value;
    logic [TAG_W-1:0] tag;      // producer tag, meaningful while not valid
    logic             valid;
  } operand_t;

  typedef struct packed {
    alu_op_e          alu_op;
    operand_t         opnd1;
    operand_t         opnd2;
    logic [TAG_W-1:0] tag_rd;
  } rs_entry_t;

  typedef struct packed {
    rob_class_e      cls;
    logic            value_ready;
    logic [XLEN-1:0] value;
    logic [4:0]      rd;
    logic [XLEN-1:0] pc_pred;
  } rob_entry_t;

endpackage

//--- hw/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
  input  logic [31:0]                     instr,
  output fetch_issue_pkg::decoded_instr_t dec
);
  import fetch_issue_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm;
  logic [2:0]      funct3;
  instr_class_e    cls;
  alu_op_e         alu_op;
  logic            uses_rs1;
  logic            uses_rs2;
  logic            writes_rd;

  assign funct3 = instr[14:12];
  assign imm_i  = {{20{instr[31]}}, instr[31:20]};
  assign imm_u  = {instr[31:12], 12'b0};
  assign imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

  always_comb begin
    cls = CLS_ILLEGAL;
    imm = '0;
    case (instr[6:0])
      OPC_LUI: begin
        cls = CLS_LUI;
        imm = imm_u;
      end
      OPC_AUIPC: begin
        cls = CLS_AUIPC;
        imm = imm_u;
      end
      OPC_JAL: begin
        cls = CLS_JAL;
        imm = imm_j;
      end
      OPC_BRANCH: begin
        cls = CLS_BRANCH;
        imm = imm_b;
      end
      OPC_OP_IMM: begin
        cls = CLS_OP_IMM;
        imm = imm_i;
      end
      OPC_OP:  cls = CLS_OP;   // no immediate
      default: ;
    endcase
  end

  assign uses_rs1  = cls inside {CLS_BRANCH, CLS_OP_IMM, CLS_OP};
  assign uses_rs2  = cls inside {CLS_BRANCH, CLS_OP};
  assign writes_rd = !(cls inside {CLS_BRANCH, CLS_ILLEGAL});

  always_comb begin
    alu_op = ALU_NOP;
    if (cls == CLS_BRANCH) begin
      case (funct3)
        3'b000:  alu_op = ALU_EQ;
        3'b001:  alu_op = ALU_NE;
        3'b100:  alu_op = ALU_LT;
        3'b101:  alu_op = ALU_GE;
        3'b110:  alu_op = ALU_LTU;
        3'b111:  alu_op = ALU_GEU;
        default: alu_op = ALU_NOP;
      endcase
    end else if (uses_rs1) begin
      case (funct3)
        3'b000:  alu_op = (cls == CLS_OP && instr[30]) ? ALU_SUB : ALU_ADD;  // no SUBI
        3'b001:  alu_op = ALU_SLL;
        3'b010:  alu_op = ALU_LT;
        3'b011:  alu_op = ALU_LTU;
        3'b100:  alu_op = ALU_XOR;
        3'b101:  alu_op = instr[30] ? ALU_SRA : ALU_SRL;
        3'b110:  alu_op = ALU_OR;
        default: alu_op = ALU_AND;
      endcase
    end
  end

  // unused source ids read as x0 so they resolve valid right away
  assign dec = '{cls:      cls,
                 rd:       writes_rd ? instr[11:7] : 5'd0,
                 rs1:      uses_rs1 ? instr[19:15] : 5'd0,
                 rs2:      uses_rs2 ? instr[24:20] : 5'd0,
                 imm:      imm,
                 alu_op:   alu_op,
                 uses_rs1: uses_rs1,
                 uses_rs2: uses_rs2};

endmodule

//--- hw/operand_resolver.sv
`timescale 1ns/1ps

module operand_resolver #(
  parameter int N_CDB = 2
) (
  input  logic [4:0]                              reg_id,
  input  logic [fetch_issue_pkg::XLEN-1:0]        rf_value,
  input  logic [fetch_issue_pkg::TAG_W-1:0]       rf_tag,
  input  logic                                    rf_valid,
  input  logic [fetch_issue_pkg::XLEN-1:0]        rob_value,
  input  logic                                    rob_ready,
  input  fetch_issue_pkg::cdb_t                   bypass,
  input  fetch_issue_pkg::cdb_t                   cdb [N_CDB],
  output fetch_issue_pkg::operand_t               opnd
);
  import fetch_issue_pkg::*;

  always_comb begin
    opnd = '{value: '0, tag: rf_tag, valid: 1'b0};
    if (reg_id == 5'd0) begin
      opnd.valid = 1'b1;  // x0 is hardwired
    end else if (rf_valid) begin
      opnd.value = rf_value;
      opnd.valid = 1'b1;
    end else if (rob_ready) begin
      opnd.value = rob_value;
      opnd.valid = 1'b1;
    end else if (bypass.valid && bypass.tag == rf_tag) begin
      // producer issued last cycle, not yet visible in the ROB
      opnd.value = bypass.value;
      opnd.valid = 1'b1;
    end else begin
      // walk downwards so the lowest matching bus wins
      for (int i = N_CDB - 1; i >= 0; i--) begin
        if (cdb[i].valid && cdb[i].tag == rf_tag) begin
          opnd.value = cdb[i].value;
          opnd.valid = 1'b1;
        end
      end
    end
  end

endmodule

//--- hw/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl #(
  parameter int LOCAL_WIDTH = 6
) (
  input  logic                            clk_in,
  input  logic                            rst_in,
  input  fetch_issue_pkg::decoded_instr_t dec,
  input  logic                            fetch_done,
  input  logic                            rs_full,
  input  logic                            rob_full,
  input  logic                            predict_jump,
  input  logic                            clear_signal,
  input  logic [31:0]                     correct_pc,
  output logic                            fetch_req,
  output logic [31:0]                     pc,
  output logic [31:0]                     alt_pc,
  output logic [LOCAL_WIDTH-1:0]          predict_addr,
  output logic                            issue_fire,
  output logic                            rf_signal
);
  import fetch_issue_pkg::*;

  logic [31:0] pc_seq;
  logic [31:0] pc_tgt;
  logic [31:0] pc_next;
  logic        take_tgt;

  assign fetch_req    = ~rs_full & ~rob_full;
  assign issue_fire   = fetch_done & fetch_req & ~clear_signal & (dec.cls != CLS_ILLEGAL);
  assign rf_signal    = issue_fire;  // rename rd only when the entry really goes out
  assign predict_addr = pc[LOCAL_WIDTH+1:2];

  assign pc_seq = pc + 32'd4;
  assign pc_tgt = pc + dec.imm;   // J- or B-immediate depending on class

  assign take_tgt = (dec.cls == CLS_JAL) || (dec.cls == CLS_BRANCH && predict_jump);
  assign pc_next  = take_tgt ? pc_tgt : pc_seq;
  assign alt_pc   = predict_jump ? pc_seq : pc_tgt;  // path the ROB falls back to

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pc <= 32'h0;
    end else if (clear_signal) begin
      pc <= correct_pc;   // mispredict wins over everything
    end else if (issue_fire) begin
      pc <= pc_next;
    end
  end

  // redirect targets and immediates must keep fetch word aligned
  a_pc_aligned: assert property (@(posedge clk_in) disable iff (rst_in)
    pc[1:0] == 2'b00);

endmodule

//--- hw/issue_regs.sv
`timescale 1ns/1ps

module issue_regs #(
  parameter int LOCAL_WIDTH = 6
) (
  input  logic                                clk_in,
  input  logic                                rst_in,
  input  logic                                issue_fire,
  input  fetch_issue_pkg::decoded_instr_t     dec,
  input  logic [31:0]                         pc,
  input  logic [31:0]                         alt_pc,
  input  logic                                predict_jump,
  input  logic [fetch_issue_pkg::TAG_W-1:0]   rob_index,
  input  fetch_issue_pkg::operand_t           opnd1,
  input  fetch_issue_pkg::operand_t           opnd2,
  output logic                                rs_issue,
  output fetch_issue_pkg::rs_entry_t          rs_entry,
  output logic                                rob_issue,
  output fetch_issue_pkg::rob_entry_t         rob_entry,
  output logic [fetch_issue_pkg::TAG_W-1:0]   rf_tag_rd,
  output fetch_issue_pkg::cdb_t               bypass
);
  import fetch_issue_pkg::*;

  logic [LOCAL_WIDTH-1:0] pred_idx;
  logic [XLEN-1:0]        rob_value_d;
  logic                   value_ready_d;
  rob_class_e             rob_cls_d;
  operand_t               opnd2_sel;
  logic                   to_rs;

  // the ROB has not advanced its index yet for the entry sent last cycle
  assign rf_tag_rd = rob_issue ? rob_index + TAG_W'(1) : rob_index;

  assign pred_idx = pc[LOCAL_WIDTH+1:2];
  assign to_rs    = dec.uses_rs1;   // branch, op-imm and op all go to the RS
  assign opnd2_sel = dec.uses_rs2 ? opnd2 : '{value: dec.imm, tag: '0, valid: 1'b1};

  always_comb begin
    rob_cls_d     = ROB_REG;
    value_ready_d = 1'b1;
    rob_value_d   = '0;
    case (dec.cls)
      CLS_LUI:   rob_value_d = dec.imm;
      CLS_AUIPC: rob_value_d = pc + dec.imm;
      CLS_JAL:   rob_value_d = pc + 32'd4;   // link address
      CLS_BRANCH: begin
        rob_cls_d     = ROB_BRANCH;
        value_ready_d = 1'b0;
        // predictor slot, fallback pc and taken bit packed for the commit check
        rob_value_d   = {pred_idx, alt_pc[31-LOCAL_WIDTH:2], predict_jump, 1'b0};
      end
      default:   value_ready_d = 1'b0;       // result comes from the ALU
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rs_issue  <= 1'b0;
      rob_issue <= 1'b0;
    end else begin
      rs_issue  <= issue_fire & to_rs;
      rob_issue <= issue_fire;
    end
  end

  always_ff @(posedge clk_in) begin
    if (issue_fire) begin
      rob_entry <= '{cls: rob_cls_d, value_ready: value_ready_d, value: rob_value_d,
                     rd: dec.rd, pc_pred: '0};
      if (to_rs) begin
        rs_entry <= '{alu_op: dec.alu_op, opnd1: opnd1, opnd2: opnd2_sel, tag_rd: rf_tag_rd};
      end
    end
  end

  assign bypass = '{valid: rob_issue & rob_entry.value_ready,
                    tag:   rob_index,
                    value: rob_entry.value};

  // a branch slot in the ROB needs its compare in the RS
  a_branch_has_rs: assert property (@(posedge clk_in) disable iff (rst_in)
    rob_issue && rob_entry.cls == ROB_BRANCH |-> rs_issue);

endmodule

//--- hw/fetch_issue_top.sv
`timescale 1ns/1ps

module fetch_issue_top #(
  parameter int LOCAL_WIDTH = 6,
  parameter int N_CDB       = 2
) (
  input  logic                              clk_in,
  input  logic                              rst_in,
  output logic                              fetch_req,
  output logic [31:0]                       fetch_addr,
  input  logic                              fetch_done,
  input  logic [31:0]                       fetch_instr,
  input  logic                              rs_full,
  input  logic                              rob_full,
  output logic                              rf_signal,
  output logic [4:0]                        rf_id_rs1,
  output logic [4:0]                        rf_id_rs2,
  output logic [4:0]                        rf_id_rd,
  output logic [fetch_issue_pkg::TAG_W-1:0] rf_tag_rd,
  input  logic [31:0]                       rf_value_rs1,
  input  logic [31:0]                       rf_value_rs2,
  input  logic [fetch_issue_pkg::TAG_W-1:0] rf_tag_rs1,
  input  logic [fetch_issue_pkg::TAG_W-1:0] rf_tag_rs2,
  input  logic                              rf_valid_rs1,
  input  logic                              rf_valid_rs2,
  input  logic [fetch_issue_pkg::TAG_W-1:0] rob_index,
  input  logic [31:0]                       rob_value_rs1,
  input  logic [31:0]                       rob_value_rs2,
  input  logic                              rob_ready_rs1,
  input  logic                              rob_ready_rs2,
  output logic [fetch_issue_pkg::TAG_W-1:0] rob_tag_rs1,
  output logic [fetch_issue_pkg::TAG_W-1:0] rob_tag_rs2,
  input  fetch_issue_pkg::cdb_t             cdb [N_CDB],
  output logic [LOCAL_WIDTH-1:0]            predict_addr,
  input  logic                              predict_jump,
  output logic                              rs_issue,
  output fetch_issue_pkg::rs_entry_t        rs_entry,
  output logic                              rob_issue,
  output fetch_issue_pkg::rob_entry_t       rob_entry,
  input  logic                              clear_signal,
  input  logic [31:0]                       correct_pc
);
  import fetch_issue_pkg::*;

  decoded_instr_t dec;
  operand_t       opnd1;
  operand_t       opnd2;
  cdb_t           bypass;
  logic [31:0]    pc;
  logic [31:0]    alt_pc;
  logic           issue_fire;

  assign fetch_addr  = pc;
  assign rf_id_rs1   = dec.rs1;
  assign rf_id_rs2   = dec.rs2;
  assign rf_id_rd    = dec.rd;
  assign rob_tag_rs1 = rf_tag_rs1;  // ROB is looked up with the RF tags
  assign rob_tag_rs2 = rf_tag_rs2;

  instr_decoder u_dec (.instr(fetch_instr), .dec);

  operand_resolver #(.N_CDB(N_CDB)) u_opnd1 (
    .reg_id(dec.rs1), .rf_value(rf_value_rs1), .rf_tag(rf_tag_rs1), .rf_valid(rf_valid_rs1),
    .rob_value(rob_value_rs1), .rob_ready(rob_ready_rs1), .bypass, .cdb, .opnd(opnd1)
  );

  operand_resolver #(.N_CDB(N_CDB)) u_opnd2 (
    .reg_id(dec.rs2), .rf_value(rf_value_rs2), .rf_tag(rf_tag_rs2), .rf_valid(rf_valid_rs2),
    .rob_value(rob_value_rs2), .rob_ready(rob_ready_rs2), .bypass, .cdb, .opnd(opnd2)
  );

  fetch_ctrl #(.LOCAL_WIDTH(LOCAL_WIDTH)) u_fetch (
    .clk_in, .rst_in, .dec, .fetch_done, .rs_full, .rob_full, .predict_jump,
    .clear_signal, .correct_pc, .fetch_req, .pc, .alt_pc, .predict_addr,
    .issue_fire, .rf_signal
  );

  issue_regs #(.LOCAL_WIDTH(LOCAL_WIDTH)) u_issue (
    .clk_in, .rst_in, .issue_fire, .dec, .pc, .alt_pc, .predict_jump, .rob_index,
    .opnd1, .opnd2, .rs_issue, .rs_entry, .rob_issue, .rob_entry, .rf_tag_rd, .bypass
  );

endmodule

//--- include/tb_issue_model.svh
`ifndef TB_ISSUE_MODEL_SVH
`define TB_ISSUE_MODEL_SVH

// immediates as the front end applies them to the pc
function automatic logic [31:0] model_b_imm(input logic [31:0] instr);
  return {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
endfunction

function automatic logic [31:0] model_j_imm(input logic [31:0] instr);
  return {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
endfunction

function automatic fetch_issue_pkg::alu_op_e model_alu_op(input logic [31:0] instr);
  fetch_issue_pkg::alu_op_e br [8];
  fetch_issue_pkg::alu_op_e ar [8];
  logic [2:0]               f3;
  br = '{fetch_issue_pkg::ALU_EQ, fetch_issue_pkg::ALU_NE, fetch_issue_pkg::ALU_NOP,
         fetch_issue_pkg::ALU_NOP, fetch_issue_pkg::ALU_LT, fetch_issue_pkg::ALU_GE,
         fetch_issue_pkg::ALU_LTU, fetch_issue_pkg::ALU_GEU};
  ar = '{fetch_issue_pkg::ALU_ADD, fetch_issue_pkg::ALU_SLL, fetch_issue_pkg::ALU_LT,
         fetch_issue_pkg::ALU_LTU, fetch_issue_pkg::ALU_XOR, fetch_issue_pkg::ALU_SRL,
         fetch_issue_pkg::ALU_OR, fetch_issue_pkg::ALU_AND};
  f3 = instr[14:12];
  if (instr[6:0] == 7'b1100011)
    return br[f3];
  if (f3 == 3'b101 && instr[30])
    return fetch_issue_pkg::ALU_SRA;
  if (f3 == 3'b000 && instr[30] && instr[6:0] == 7'b0110011)
    return fetch_issue_pkg::ALU_SUB;
  return ar[f3];
endfunction

function automatic logic [31:0] model_next_pc(input logic [31:0] pc, input logic [31:0] instr,
                                              input logic taken);
  if (instr[6:0] == 7'b1101111)
    return pc + model_j_imm(instr);
  if (instr[6:0] == 7'b1100011 && taken)
    return pc + model_b_imm(instr);
  return pc + 32'd4;
endfunction

// bus list fixed at the default of two result buses
function automatic fetch_issue_pkg::operand_t model_operand(
    input logic [4:0] id, input logic [31:0] rf_value, input logic [3:0] rf_tag,
    input logic rf_valid, input logic [31:0] rob_value, input logic rob_ready,
    input fetch_issue_pkg::cdb_t byp, input fetch_issue_pkg::cdb_t buses [2]);
  fetch_issue_pkg::operand_t o;
  o = '{value: '0, tag: rf_tag, valid: 1'b1};
  if (id == 5'd0)
    return o;
  if (rf_valid)
    o.value = rf_value;
  else if (rob_ready)
    o.value = rob_value;
  else if (byp.valid && byp.tag == rf_tag)
    o.value = byp.value;
  else if (buses[0].valid && buses[0].tag == rf_tag)
    o.value = buses[0].value;
  else if (buses[1].valid && buses[1].tag == rf_tag)
    o.value = buses[1].value;
  else
    o.valid = 1'b0;
  return o;
endfunction

// expected ROB value for a branch, lw is the predictor index width
function automatic logic [31:0] model_branch_word(input logic [31:0] pc, input logic [31:0] alt,
                                                  input logic taken, input int lw);
  logic [31:0] idx;
  logic [31:0] mid_mask;
  idx      = (pc >> 2) & ((32'd1 << lw) - 32'd1);
  mid_mask = (32'hFFFF_FFFF >> lw) & ~32'h3;
  return (idx << (32 - lw)) | (alt & mid_mask) | {30'd0, taken, 1'b0};
endfunction

`endif

//--- tests/tb_fetch_issue.sv
`timescale 1ns/1ps

module tb_fetch_issue;
  import fetch_issue_pkg::*;

  `include "tb_issue_model.svh"

  localparam int LW          = 6;
  localparam int RESET_CYC   = 4;
  localparam int MIX_CYC     = 2000;
  localparam int BUSY_CYC    = 1000;
  localparam int REDIR_CYC   = 1000;
  localparam int TOTAL_CYC   = RESET_CYC + MIX_CYC + BUSY_CYC + REDIR_CYC;
  localparam int CYCLE_LIMIT = 2 * TOTAL_CYC + 100;

  logic             clk_in;
  logic             rst_in;
  logic             fetch_req;
  logic [31:0]      fetch_addr;
  logic             fetch_done;
  logic [31:0]      fetch_instr;
  logic             rs_full;
  logic             rob_full;
  logic             rf_signal;
  logic [4:0]       rf_id_rs1;
  logic [4:0]       rf_id_rs2;
  logic [4:0]       rf_id_rd;
  logic [TAG_W-1:0] rf_tag_rd;
  logic [31:0]      rf_value_rs1;
  logic [31:0]      rf_value_rs2;
  logic [TAG_W-1:0] rf_tag_rs1;
  logic [TAG_W-1:0] rf_tag_rs2;
  logic             rf_valid_rs1;
  logic             rf_valid_rs2;
  logic [TAG_W-1:0] rob_index;
  logic [31:0]      rob_value_rs1;
  logic [31:0]      rob_value_rs2;
  logic             rob_ready_rs1;
  logic             rob_ready_rs2;
  logic [TAG_W-1:0] rob_tag_rs1;
  logic [TAG_W-1:0] rob_tag_rs2;
  cdb_t             cdb [2];
  logic [LW-1:0]    predict_addr;
  logic             predict_jump;
  logic             rs_issue;
  rs_entry_t        rs_entry;
  logic             rob_issue;
  rob_entry_t       rob_entry;
  logic             clear_signal;
  logic [31:0]      correct_pc;

  // model state, describes what the DUT should show after the next edge
  logic [31:0] exp_pc;
  logic        exp_rs_issue;
  logic        exp_rob_issue;
  logic        exp_rob_value_known;
  rs_entry_t   exp_rs;
  rob_entry_t  exp_rob;

  int checks;
  int errors;
  int test_checks;
  int test_errors;
  int cycles;

  fetch_issue_top #(.LOCAL_WIDTH(LW), .N_CDB(2)) u_dut (.*);

  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  always @(posedge clk_in) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  task automatic compare(input string sig, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    test_checks++;
    assert (got === exp) else begin
      $display("[FAIL] t=%0t %s got %0h expected %0h", $time, sig, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  // one random legal instruction plus a random environment for this cycle
  task automatic drive_random(input int busy_pct, input int clear_pct);
    logic [31:0] instr;
    logic [2:0]  br_f3 [6];
    br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    instr = $urandom();
    case ($urandom_range(0, 5))
      0: instr[6:0] = OPC_LUI;
      1: instr[6:0] = OPC_AUIPC;
      2: begin
        instr[6:0] = OPC_JAL;
        instr[21]  = 1'b0;   // keeps the jump target word aligned
      end
      3: begin
        instr[6:0]   = OPC_BRANCH;
        instr[8]     = 1'b0;
        instr[14:12] = br_f3[$urandom_range(0, 5)];
      end
      4: instr[6:0] = OPC_OP_IMM;
      default: instr[6:0] = OPC_OP;
    endcase
    if ($urandom_range(0, 7) == 0) instr[19:15] = 5'd0;
    if ($urandom_range(0, 7) == 0) instr[24:20] = 5'd0;
    fetch_instr   <= instr;
    fetch_done    <= ($urandom_range(0, 99) >= busy_pct);
    rs_full       <= ($urandom_range(0, 99) < busy_pct / 2);
    rob_full      <= ($urandom_range(0, 99) < busy_pct / 2);
    clear_signal  <= ($urandom_range(0, 99) < clear_pct);
    correct_pc    <= $urandom() & 32'hFFFF_FFFC;
    predict_jump  <= 1'($urandom_range(0, 1));
    rf_value_rs1  <= $urandom();
    rf_value_rs2  <= $urandom();
    rf_tag_rs1    <= 4'($urandom_range(0, 3));   // small tag range so matches happen
    rf_tag_rs2    <= 4'($urandom_range(0, 3));
    rf_valid_rs1  <= ($urandom_range(0, 2) == 0);
    rf_valid_rs2  <= ($urandom_range(0, 2) == 0);
    rob_value_rs1 <= $urandom();
    rob_value_rs2 <= $urandom();
    rob_ready_rs1 <= ($urandom_range(0, 2) == 0);
    rob_ready_rs2 <= ($urandom_range(0, 2) == 0);
    rob_index     <= ($urandom_range(0, 7) == 0) ? 4'hF : 4'($urandom_range(0, 3));
    for (int i = 0; i < 2; i++) begin
      cdb[i] <= '{valid: 1'($urandom_range(0, 1)), tag: 4'($urandom_range(0, 3)),
                  value: $urandom()};
    end
  endtask

  // compare what the last edge produced, then predict the coming edge
  task automatic check_cycle();
    logic [31:0] instr;
    logic [31:0] alt;
    logic [3:0]  exp_tag;
    logic        fire;
    logic        to_rs;
    logic        uses_rs2;
    cdb_t        byp;
    instr = fetch_instr;
    compare("fetch_addr", 128'(fetch_addr), 128'(exp_pc));
    compare("predict_addr", 128'(predict_addr), 128'(exp_pc[LW+1:2]));
    compare("rob_issue", 128'(rob_issue), 128'(exp_rob_issue));
    compare("rs_issue", 128'(rs_issue), 128'(exp_rs_issue));
    if (exp_rob_issue) begin
      compare("rob_entry.cls", 128'(rob_entry.cls), 128'(exp_rob.cls));
      compare("rob_entry.value_ready", 128'(rob_entry.value_ready), 128'(exp_rob.value_ready));
      compare("rob_entry.rd", 128'(rob_entry.rd), 128'(exp_rob.rd));
      compare("rob_entry.pc_pred", 128'(rob_entry.pc_pred), 128'(exp_rob.pc_pred));
      if (exp_rob_value_known)
        compare("rob_entry.value", 128'(rob_entry.value), 128'(exp_rob.value));
    end
    if (exp_rs_issue) compare("rs_entry", 128'(rs_entry), 128'(exp_rs));
    exp_tag = rob_index + 4'(exp_rob_issue);
    compare("rf_tag_rd", 128'(rf_tag_rd), 128'(exp_tag));
    fire = fetch_done && !rs_full && !rob_full && !clear_signal;
    compare("fetch_req", 128'(fetch_req), 128'(!(rs_full || rob_full)));
    compare("rf_signal", 128'(rf_signal), 128'(fire));
    // last cycle's entry, seen under the current rob_index
    byp = '{valid: exp_rob_issue && exp_rob.value_ready, tag: rob_index, value: exp_rob.value};
    to_rs = instr[6:0] inside {OPC_BRANCH, OPC_OP_IMM, OPC_OP};
    uses_rs2 = instr[6:0] inside {OPC_BRANCH, OPC_OP};
    compare("rob_tag_rs1", 128'(rob_tag_rs1), 128'(rf_tag_rs1));
    compare("rob_tag_rs2", 128'(rob_tag_rs2), 128'(rf_tag_rs2));
    if (to_rs) compare("rf_id_rs1", 128'(rf_id_rs1), 128'(instr[19:15]));
    if (uses_rs2) compare("rf_id_rs2", 128'(rf_id_rs2), 128'(instr[24:20]));
    if (instr[6:0] != OPC_BRANCH) compare("rf_id_rd", 128'(rf_id_rd), 128'(instr[11:7]));
    if (fire) begin
      alt = predict_jump ? exp_pc + 32'd4 : exp_pc + model_b_imm(instr);
      exp_rob = '{cls: ROB_REG, value_ready: 1'b1, value: '0, rd: instr[11:7], pc_pred: '0};
      exp_rob_value_known = 1'b1;
      case (instr[6:0])
        OPC_LUI:   exp_rob.value = {instr[31:12], 12'b0};
        OPC_AUIPC: exp_rob.value = exp_pc + {instr[31:12], 12'b0};
        OPC_JAL:   exp_rob.value = exp_pc + 32'd4;
        OPC_BRANCH: begin
          exp_rob.cls         = ROB_BRANCH;
          exp_rob.value_ready = 1'b0;
          exp_rob.rd          = 5'd0;
          exp_rob.value       = model_branch_word(exp_pc, alt, predict_jump, LW);
        end
        default: begin
          exp_rob.value_ready = 1'b0;   // alu result arrives later
          exp_rob_value_known = 1'b0;
        end
      endcase
      if (to_rs) begin
        exp_rs.alu_op = model_alu_op(instr);
        exp_rs.opnd1  = model_operand(instr[19:15], rf_value_rs1, rf_tag_rs1, rf_valid_rs1,
                                      rob_value_rs1, rob_ready_rs1, byp, cdb);
        if (instr[6:0] == OPC_OP_IMM)
          exp_rs.opnd2 = '{value: {{20{instr[31]}}, instr[31:20]}, tag: '0, valid: 1'b1};
        else
          exp_rs.opnd2 = model_operand(instr[24:20], rf_value_rs2, rf_tag_rs2, rf_valid_rs2,
                                       rob_value_rs2, rob_ready_rs2, byp, cdb);
        exp_rs.tag_rd = exp_tag;
      end
      exp_pc = model_next_pc(exp_pc, instr, predict_jump);
    end else if (clear_signal) begin
      exp_pc = correct_pc;
    end
    exp_rob_issue = fire;
    exp_rs_issue  = fire && to_rs;
  endtask

  task automatic run_phase(input string name, input int n, input int busy_pct,
                           input int clear_pct);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_in);
      drive_random(busy_pct, clear_pct);
      @(negedge clk_in);
      check_cycle();
    end
    report_test(name);
  endtask

  initial begin
    void'($urandom(21));
    checks = 0;
    errors = 0;
    test_checks = 0;
    test_errors = 0;
    cycles = 0;
    rst_in = 1'b1;
    fetch_done = 1'b1;
    fetch_instr = 32'h0000_0033;   // legal op offered while reset is high
    rs_full = 1'b0;
    rob_full = 1'b0;
    rf_value_rs1 = 32'h0;
    rf_value_rs2 = 32'h0;
    rf_tag_rs1 = '0;
    rf_tag_rs2 = '0;
    rf_valid_rs1 = 1'b0;
    rf_valid_rs2 = 1'b0;
    rob_index = '0;
    rob_value_rs1 = 32'h0;
    rob_value_rs2 = 32'h0;
    rob_ready_rs1 = 1'b0;
    rob_ready_rs2 = 1'b0;
    cdb[0] = '0;
    cdb[1] = '0;
    predict_jump = 1'b0;
    clear_signal = 1'b0;
    correct_pc = 32'h0;
    exp_pc = 32'h0;
    exp_rs_issue = 1'b0;
    exp_rob_issue = 1'b0;
    exp_rob_value_known = 1'b0;
    exp_rs = '0;
    exp_rob = '0;

    repeat (RESET_CYC) @(posedge clk_in);
    rst_in <= 1'b0;
    fetch_done <= 1'b0;
    @(negedge clk_in);
    compare("rs_issue", 128'(rs_issue), 128'(0));
    compare("rob_issue", 128'(rob_issue), 128'(0));
    compare("fetch_addr", 128'(fetch_addr), 128'(0));
    report_test("reset");

    run_phase("random mix", MIX_CYC, 20, 2);
    run_phase("heavy back-pressure", BUSY_CYC, 60, 1);
    run_phase("frequent redirects", REDIR_CYC, 10, 15);

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- fetch_issue_top.f
+incdir+include
hw/fetch_issue_pkg.sv
hw/instr_decoder.sv
hw/operand_resolver.sv
hw/fetch_ctrl.sv
hw/issue_regs.sv
hw/fetch_issue_top.sv
tests/tb_fetch_issue.sv

//--- Makefile
VERILATOR  ?= verilator
TB_TOP     ?= tb_fetch_issue
RTL_TOP    ?= fetch_issue_top
FILELIST   ?= fetch_issue_top.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= -j 0
LINT_FLAGS ?=
PASS_MSG   ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TB_TOP) \
	  -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TB_TOP)

run: build
	@out="$$(./$(BUILD_DIR)/$(TB_TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
